// ==== hw/mipsPkg.sv ====
package mipsPkg;

    // primary opcodes from instr[31:26]
    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opJal   = 6'h03;

    // funct field of R-type
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnJr   = 6'h08;

    // operand source selects
    localparam logic [1:0] fwdNone = 2'd0;
    localparam logic [1:0] fwdMem  = 2'd1;
    localparam logic [1:0] fwdWb   = 2'd2;

    // alu operations
    localparam logic [1:0] aluAdd = 2'd0;
    localparam logic [1:0] aluSub = 2'd1;
    localparam logic [1:0] aluOr  = 2'd2;
    localparam logic [1:0] aluLui = 2'd3;

    // tuse in cycles after decode
    localparam logic [2:0] tuseBranch = 3'd0;
    localparam logic [2:0] tuseAlu    = 3'd1;
    localparam logic [2:0] tuseStore  = 3'd2;
    // operand not read at all
    localparam logic [2:0] tuseNone   = 3'd7;

    // tnew as seen in execute
    localparam logic [2:0] tnewAlu  = 3'd1;
    localparam logic [2:0] tnewLoad = 3'd2;
    localparam logic [2:0] tnewLink = 3'd0;

    localparam logic [31:0] resetPc = 32'h0000_0000;
    localparam logic [4:0]  linkReg = 5'd31;

    // fetch to decode
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pcPlus8;
    } fetchDecodeT;

    // decode to execute
    typedef struct packed {
        logic [1:0]  aluOp;
        logic        useImm;
        logic        isLoad;
        logic        isStore;
        logic        isJal;
        logic        regWrite;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] imm;
        logic [31:0] pcPlus8;
        logic [4:0]  dest;
        logic [2:0]  tnew;
    } decodeExecT;

    // execute to memory
    typedef struct packed {
        logic [31:0] result;
        logic [31:0] storeData;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic        regWrite;
        logic        isLoad;
        logic        isStore;
        logic [2:0]  tnew;
    } execMemT;

    // memory to write-back
    typedef struct packed {
        logic [31:0] wbData;
        logic [4:0]  dest;
        logic        regWrite;
    } memWbT;

endpackage

// ==== hw/pipeReg.sv ====
`timescale 1ns/10ps

module pipeReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // all-zero payload is a bubble
    // write enables and store flag low
    // flush beats stall so a held stage can still be emptied
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/10ps

module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic        we,
    input  logic [4:0]  readAddr1,
    input  logic [4:0]  readAddr2,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData,
    output logic [31:0] readData1,
    output logic [31:0] readData2
);

    logic [31:0] regs [32];

    // $zero is never stored
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // write-before-read
    // same-cycle write-back value goes straight to decode
    assign readData1 = (readAddr1 == 5'd0) ? 32'd0 :
                       (we && writeAddr == readAddr1) ? writeData : regs[readAddr1];
    assign readData2 = (readAddr2 == 5'd0) ? 32'd0 :
                       (we && writeAddr == readAddr2) ? writeData : regs[readAddr2];

endmodule

// ==== hw/instrDecode.sv ====
`timescale 1ns/10ps

module instrDecode (
    input  logic [31:0] instr,
    output logic [1:0]  aluOp,
    output logic        useImm,
    output logic        zeroExt,
    output logic        isLoad,
    output logic        isStore,
    output logic        isBranch,
    output logic        isJump,
    output logic        isJr,
    output logic        isJal,
    output logic        regWrite,
    output logic [4:0]  destAddr,
    output logic [2:0]  tuseRs,
    output logic [2:0]  tuseRt,
    output logic [2:0]  tnewE
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        // defaults give a no-op
        aluOp    = aluAdd;
        useImm   = 1'b0;
        zeroExt  = 1'b0;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        isBranch = 1'b0;
        isJump   = 1'b0;
        isJr     = 1'b0;
        isJal    = 1'b0;
        regWrite = 1'b0;
        destAddr = 5'd0;
        tuseRs   = tuseNone;
        tuseRt   = tuseNone;
        tnewE    = 3'd0;
        case (opcode)
            opRtype: begin
                if (funct == fnAddu || funct == fnSubu) begin
                    aluOp    = (funct == fnSubu) ? aluSub : aluAdd;
                    regWrite = 1'b1;
                    destAddr = instr[15:11];
                    tuseRs   = tuseAlu;
                    tuseRt   = tuseAlu;
                    tnewE    = tnewAlu;
                end else if (funct == fnJr) begin
                    // target needed in decode
                    isJr   = 1'b1;
                    tuseRs = tuseBranch;
                end
            end
            opOri, opLui: begin
                aluOp    = (opcode == opOri) ? aluOr : aluLui;
                useImm   = 1'b1;
                zeroExt  = (opcode == opOri);
                regWrite = 1'b1;
                destAddr = instr[20:16];
                // lui ignores rs
                tuseRs   = (opcode == opOri) ? tuseAlu : tuseNone;
                tnewE    = tnewAlu;
            end
            opLw: begin
                useImm   = 1'b1;
                isLoad   = 1'b1;
                regWrite = 1'b1;
                destAddr = instr[20:16];
                tuseRs   = tuseAlu;
                tnewE    = tnewLoad;
            end
            opSw: begin
                useImm  = 1'b1;
                isStore = 1'b1;
                tuseRs  = tuseAlu;
                // store data only needed at the memory stage
                tuseRt  = tuseStore;
            end
            opBeq: begin
                isBranch = 1'b1;
                tuseRs   = tuseBranch;
                tuseRt   = tuseBranch;
            end
            opJ: begin
                isJump = 1'b1;
            end
            opJal: begin
                isJump   = 1'b1;
                isJal    = 1'b1;
                regWrite = 1'b1;
                destAddr = linkReg;
                // link value known from decode on
                tnewE    = tnewLink;
            end
            default: begin
                isJump = 1'b0;
            end
        endcase
    end

endmodule

// ==== hw/hazardUnit.sv ====
`timescale 1ns/10ps

module hazardUnit (
    input  logic [4:0] rsD,
    input  logic [4:0] rtD,
    input  logic [4:0] rsE,
    input  logic [4:0] rtE,
    input  logic [4:0] rtM,
    input  logic [4:0] destE,
    input  logic [4:0] destM,
    input  logic [4:0] destW,
    input  logic       regWriteE,
    input  logic       regWriteM,
    input  logic       regWriteW,
    input  logic [2:0] tuseRs,
    input  logic [2:0] tuseRt,
    input  logic [2:0] tnewE,
    input  logic [2:0] tnewM,
    output logic [1:0] fwdCmpA,
    output logic [1:0] fwdCmpB,
    output logic [1:0] fwdAluA,
    output logic [1:0] fwdAluB,
    output logic [1:0] fwdStore,
    output logic       stall
);
    import mipsPkg::*;

    // memory-stage value usable only once it is final
    // loads still in memory have tnew 1
    function automatic logic memHit(input logic [4:0] src);
        return regWriteM && tnewM == 3'd0 && destM == src && src != 5'd0;
    endfunction

    function automatic logic wbHit(input logic [4:0] src);
        return regWriteW && destW == src && src != 5'd0;
    endfunction

    // producer result arrives after the decode-stage consumer needs it
    // both write enable and $zero guard cover rs and rt
    function automatic logic tooLate(
        input logic       we,
        input logic [4:0] dest,
        input logic [2:0] tnew
    );
        logic rsLate;
        logic rtLate;
        rsLate = (rsD == dest) && (tnew > tuseRs);
        rtLate = (rtD == dest) && (tnew > tuseRt);
        return we && dest != 5'd0 && (rsLate || rtLate);
    endfunction

    always_comb begin
        // decode comparator
        // write-back values already come through the register file
        fwdCmpA = memHit(rsD) ? fwdMem : fwdNone;
        fwdCmpB = memHit(rtD) ? fwdMem : fwdNone;

        // alu inputs with memory stage ahead of write-back
        if (memHit(rsE)) begin
            fwdAluA = fwdMem;
        end else if (wbHit(rsE)) begin
            fwdAluA = fwdWb;
        end else begin
            fwdAluA = fwdNone;
        end

        // rt path also feeds the store data captured in execute
        if (memHit(rtE)) begin
            fwdAluB = fwdMem;
        end else if (wbHit(rtE)) begin
            fwdAluB = fwdWb;
        end else begin
            fwdAluB = fwdNone;
        end

        // load feeding a store right behind it
        fwdStore = wbHit(rtM) ? fwdWb : fwdNone;

        // hold fetch and decode
        // core turns the same signal into an execute bubble
        stall = tooLate(regWriteE, destE, tnewE) || tooLate(regWriteM, destM, tnewM);
    end

endmodule

// ==== hw/pipelineCore.sv ====
`timescale 1ns/10ps

module pipelineCore (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] imemAddr,
    input  logic [31:0] imemData,
    output logic [31:0] dmemAddr,
    output logic        dmemWe,
    output logic [31:0] dmemWdata,
    input  logic [31:0] dmemRdata
);
    import mipsPkg::*;

    logic [31:0] pc;
    logic [31:0] pcNext;

    // stage registers
    fetchDecodeT fdD;
    fetchDecodeT fdQ;
    decodeExecT  deD;
    decodeExecT  deQ;
    execMemT     emD;
    execMemT     emQ;
    memWbT       mwD;
    memWbT       mwQ;

    // decode stage
    logic [31:0] instrD;
    logic [4:0]  rsD;
    logic [4:0]  rtD;
    logic [31:0] rsValD;
    logic [31:0] rtValD;
    logic [31:0] immD;
    logic [31:0] pcPlus4D;
    logic [31:0] cmpA;
    logic [31:0] cmpB;
    logic [1:0]  aluOpD;
    logic        useImmD;
    logic        zeroExtD;
    logic        isLoadD;
    logic        isStoreD;
    logic        isBranchD;
    logic        isJumpD;
    logic        isJrD;
    logic        isJalD;
    logic        regWriteD;
    logic [4:0]  destD;
    logic [2:0]  tuseRs;
    logic [2:0]  tuseRt;
    logic [2:0]  tnewD;

    // execute stage
    logic [31:0] srcA;
    logic [31:0] rtFwdE;
    logic [31:0] srcB;
    logic [31:0] aluOut;

    // hazard selects
    logic [1:0] fwdCmpA;
    logic [1:0] fwdCmpB;
    logic [1:0] fwdAluA;
    logic [1:0] fwdAluB;
    logic [1:0] fwdStore;
    logic       stall;

    // memory result already holds the jal link
    function automatic logic [31:0] fwdPick(input logic [1:0] sel, input logic [31:0] regVal);
        case (sel)
            fwdMem:  return emQ.result;
            fwdWb:   return mwQ.wbData;
            default: return regVal;
        endcase
    endfunction

    // fetch
    assign imemAddr = pc;
    assign fdD      = '{instr: imemData, pcPlus8: pc + 32'd8};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetPc;
        end else if (!stall) begin
            pc <= pcNext;
        end
    end

    pipeReg #(.payloadT(fetchDecodeT)) fetchDecodeReg (
        .clk(clk), .rst(rst), .stall(stall), .flush(1'b0), .d(fdD), .q(fdQ)
    );

    // decode
    assign instrD   = fdQ.instr;
    assign rsD      = instrD[25:21];
    assign rtD      = instrD[20:16];
    assign pcPlus4D = fdQ.pcPlus8 - 32'd4;
    assign immD     = zeroExtD ? {16'h0, instrD[15:0]} : {{16{instrD[15]}}, instrD[15:0]};

    regFile regFile_i (
        .clk(clk), .rst(rst), .we(mwQ.regWrite),
        .readAddr1(rsD), .readAddr2(rtD), .writeAddr(mwQ.dest), .writeData(mwQ.wbData),
        .readData1(rsValD), .readData2(rtValD)
    );

    instrDecode instrDecode_i (
        .instr(instrD), .aluOp(aluOpD), .useImm(useImmD), .zeroExt(zeroExtD),
        .isLoad(isLoadD), .isStore(isStoreD), .isBranch(isBranchD), .isJump(isJumpD),
        .isJr(isJrD), .isJal(isJalD), .regWrite(regWriteD), .destAddr(destD),
        .tuseRs(tuseRs), .tuseRt(tuseRt), .tnewE(tnewD)
    );

    // branch compare and redirect
    // the delay slot is being fetched meanwhile
    always_comb begin
        cmpA = fwdPick(fwdCmpA, rsValD);
        cmpB = fwdPick(fwdCmpB, rtValD);
        if (isJrD) begin
            pcNext = cmpA;
        end else if (isJumpD) begin
            pcNext = {pcPlus4D[31:28], instrD[25:0], 2'b00};
        end else if (isBranchD && cmpA == cmpB) begin
            pcNext = pcPlus4D + {immD[29:0], 2'b00};
        end else begin
            pcNext = pc + 32'd4;
        end
    end

    assign deD = '{
        aluOp:    aluOpD,
        useImm:   useImmD,
        isLoad:   isLoadD,
        isStore:  isStoreD,
        isJal:    isJalD,
        regWrite: regWriteD,
        rs:       rsD,
        rt:       rtD,
        rsVal:    rsValD,
        rtVal:    rtValD,
        imm:      immD,
        pcPlus8:  fdQ.pcPlus8,
        dest:     destD,
        tnew:     tnewD
    };

    // bubble into execute while decode waits
    pipeReg #(.payloadT(decodeExecT)) decodeExecReg (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(stall), .d(deD), .q(deQ)
    );

    // execute
    always_comb begin
        srcA   = fwdPick(fwdAluA, deQ.rsVal);
        rtFwdE = fwdPick(fwdAluB, deQ.rtVal);
        srcB   = deQ.useImm ? deQ.imm : rtFwdE;
        case (deQ.aluOp)
            aluSub:  aluOut = srcA - srcB;
            aluOr:   aluOut = srcA | srcB;
            aluLui:  aluOut = {srcB[15:0], 16'h0};
            default: aluOut = srcA + srcB;
        endcase
    end

    // link value chosen here so forwarding needs no jal case
    // tnew counts down with a floor of zero
    assign emD = '{
        result:    deQ.isJal ? deQ.pcPlus8 : aluOut,
        storeData: rtFwdE,
        rt:        deQ.rt,
        dest:      deQ.dest,
        regWrite:  deQ.regWrite,
        isLoad:    deQ.isLoad,
        isStore:   deQ.isStore,
        tnew:      (deQ.tnew == 3'd0) ? 3'd0 : deQ.tnew - 3'd1
    };

    pipeReg #(.payloadT(execMemT)) execMemReg (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0), .d(emD), .q(emQ)
    );

    // memory
    assign dmemAddr  = emQ.result;
    assign dmemWe    = emQ.isStore;
    assign dmemWdata = (fwdStore == fwdWb) ? mwQ.wbData : emQ.storeData;

    assign mwD = '{
        wbData:   emQ.isLoad ? dmemRdata : emQ.result,
        dest:     emQ.dest,
        regWrite: emQ.regWrite
    };

    pipeReg #(.payloadT(memWbT)) memWbReg (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0), .d(mwD), .q(mwQ)
    );

    hazardUnit hazardUnit_i (
        .rsD(rsD), .rtD(rtD), .rsE(deQ.rs), .rtE(deQ.rt), .rtM(emQ.rt),
        .destE(deQ.dest), .destM(emQ.dest), .destW(mwQ.dest),
        .regWriteE(deQ.regWrite), .regWriteM(emQ.regWrite), .regWriteW(mwQ.regWrite),
        .tuseRs(tuseRs), .tuseRt(tuseRt), .tnewE(deQ.tnew), .tnewM(emQ.tnew),
        .fwdCmpA(fwdCmpA), .fwdCmpB(fwdCmpB), .fwdAluA(fwdAluA), .fwdAluB(fwdAluB),
        .fwdStore(fwdStore), .stall(stall)
    );

endmodule

// ==== verification/clockGen.sv ====
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // reset spans the first 16 rising edges
    // released just after the edge like every other input
    initial begin
        rst = 1'b1;
        repeat (16) begin
            @(posedge clk);
        end
        #1 rst = 1'b0;
    end

endmodule

// ==== verification/core_asserts.sv ====
`timescale 1ns/10ps

module coreAsserts (
    input logic       clk,
    input logic       rst,
    input logic [4:0] rsD,
    input logic [4:0] rtD,
    input logic [4:0] rsE,
    input logic [4:0] rtE,
    input logic [4:0] rtM,
    input logic [1:0] fwdCmpA,
    input logic [1:0] fwdCmpB,
    input logic [1:0] fwdAluA,
    input logic [1:0] fwdAluB,
    input logic [1:0] fwdStore,
    input logic       dmemWe
);
    import mipsPkg::*;

    // $zero has no producer, so no select may point at one
    cmpAZero: assert property (@(posedge clk) disable iff (rst)
        rsD == 5'd0 |-> fwdCmpA == fwdNone)
        else $error("decode compare A forwarded for register 0");
    cmpBZero: assert property (@(posedge clk) disable iff (rst)
        rtD == 5'd0 |-> fwdCmpB == fwdNone)
        else $error("decode compare B forwarded for register 0");
    aluAZero: assert property (@(posedge clk) disable iff (rst)
        rsE == 5'd0 |-> fwdAluA == fwdNone)
        else $error("alu input A forwarded for register 0");
    aluBZero: assert property (@(posedge clk) disable iff (rst)
        rtE == 5'd0 |-> fwdAluB == fwdNone)
        else $error("alu input B forwarded for register 0");
    storeZero: assert property (@(posedge clk) disable iff (rst)
        rtM == 5'd0 |-> fwdStore == fwdNone)
        else $error("store data forwarded for register 0");

    // write enable must be a clean level once out of reset
    weKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(dmemWe))
        else $error("data memory write enable is unknown");

endmodule

// hazard selects and the memory port both live at core level
bind pipelineCore coreAsserts coreAsserts_i (
    .clk(clk), .rst(rst), .rsD(rsD), .rtD(rtD), .rsE(deQ.rs), .rtE(deQ.rt), .rtM(emQ.rt),
    .fwdCmpA(fwdCmpA), .fwdCmpB(fwdCmpB), .fwdAluA(fwdAluA), .fwdAluB(fwdAluB),
    .fwdStore(fwdStore), .dmemWe(dmemWe)
);

// ==== verification/coreTb.sv ====
`timescale 1ns/10ps

module coreTb;
    import mipsPkg::*;

    // pattern image layout in words
    localparam int patWords  = 256;
    localparam int dataBase  = 64;
    localparam int storeBase = 96;
    // first data word sits at byte 0x100
    localparam int dataWord  = 64;
    localparam int memWords  = 256;
    localparam int maxStores = 64;
    localparam int resetTimeout = 100;
    localparam int storeTimeout = 200;
    localparam int quietCycles  = 50;
    localparam logic [31:0] fillSeed = 32'h4292cebd;

    logic        clk;
    logic        rst;
    logic [31:0] imemAddr;
    logic [31:0] imemData;
    logic [31:0] dmemAddr;
    logic        dmemWe;
    logic [31:0] dmemWdata;
    logic [31:0] dmemRdata;

    logic [31:0] patterns [patWords];
    logic [31:0] imem [memWords];
    logic [31:0] dmem [memWords];
    // stores in the order the core made them
    logic [31:0] storeAddr [maxStores];
    logic [31:0] storeData [maxStores];
    int          storeTotal;

    clockGen clockGen_i (.clk(clk), .rst(rst));

    pipelineCore pipelineCore_i (
        .clk(clk), .rst(rst), .imemAddr(imemAddr), .imemData(imemData),
        .dmemAddr(dmemAddr), .dmemWe(dmemWe), .dmemWdata(dmemWdata), .dmemRdata(dmemRdata)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic stopWithError(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            stopWithError($sformatf("[FAIL] %s expected %08h actual %08h",
                                    testName, expected, actual));
        end
    endtask

    // both memories answer 1 ns after the edge
    initial begin
        int dataCount;
        imemData = '0;
        dmemRdata = '0;
        storeTotal = 0;
        for (int i = 0; i < patWords; i++) begin
            patterns[i] = '0;
        end
        $readmemh("verification/corePatterns.txt", patterns);
        for (int i = 0; i < memWords; i++) begin
            imem[i] = (i < dataBase) ? patterns[i] : '0;
            // a stale read cannot hit a meaningful value
            dmem[i] = xorshift(fillSeed ^ (32'(i) << 2));
        end
        dataCount = int'(patterns[dataBase]);
        for (int k = 0; k < dataCount; k++) begin
            dmem[dataWord + k] = patterns[dataBase + 1 + k];
        end
        forever begin
            @(posedge clk);
            #1;
            if (dmemWe === 1'b1) begin
                if (storeTotal < maxStores) begin
                    storeAddr[storeTotal] = dmemAddr;
                    storeData[storeTotal] = dmemWdata;
                end
                storeTotal++;
                dmem[dmemAddr[9:2]] = dmemWdata;
            end
            imemData = imem[imemAddr[9:2]];
            dmemRdata = dmem[dmemAddr[9:2]];
        end
    end

    initial begin
        int          storeCount;
        int          waitCycles;
        logic [31:0] expAddr;
        logic [31:0] expData;
        waitCycles = 0;
        do begin
            @(negedge clk);
            waitCycles++;
            if (waitCycles > resetTimeout) begin
                stopWithError("reset was never released");
            end
        end while (rst !== 1'b0);

        // no edge yet since release, so the core still shows its reset state
        checkValue("reset fetch address", resetPc, imemAddr);
        checkValue("reset store enable", 32'd0, 32'(dmemWe));

        storeCount = int'(patterns[storeBase]);
        if (storeCount == 0 || storeCount >= maxStores) begin
            stopWithError("pattern file gives no usable store count");
        end

        // stores must arrive in program order
        for (int n = 0; n < storeCount; n++) begin
            expAddr = patterns[storeBase + 1 + 2 * n];
            expData = patterns[storeBase + 2 + 2 * n];
            waitCycles = 0;
            while (storeTotal <= n) begin
                @(negedge clk);
                waitCycles++;
                if (waitCycles > storeTimeout) begin
                    stopWithError($sformatf("store %0d to %08h never arrived", n, expAddr));
                end
            end
            checkValue($sformatf("store %0d address", n), expAddr, storeAddr[n]);
            checkValue($sformatf("store %0d data", n), expData, storeData[n]);
        end

        // program now spins in its end loop
        waitCycles = 0;
        while (waitCycles < quietCycles) begin
            @(negedge clk);
            waitCycles++;
            if (storeTotal > storeCount) begin
                stopWithError($sformatf("unexpected store to %08h", storeAddr[storeCount]));
            end
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== verification/corePatterns.txt ====
// @00 program words, byte address and assembly in the comment
// @40 count of data words, then the words placed from data byte address 0x100 up
// @60 count of expected stores, then one store per line as address then data
@00
34010010 // 00 ori  $1, $0, 0x10
34020020 // 04 ori  $2, $0, 0x20
00221821 // 08 addu $3, $1, $2
00612021 // 0c addu $4, $3, $1
00832821 // 10 addu $5, $4, $3
340a0200 // 14 ori  $10, $0, 0x200
ad450000 // 18 sw   $5, 0($10)
34060005 // 1c ori  $6, $0, 5
34070001 // 20 ori  $7, $0, 1
34080002 // 24 ori  $8, $0, 2
00c74823 // 28 subu $9, $6, $7
ad490004 // 2c sw   $9, 4($10)
340b0100 // 30 ori  $11, $0, 0x100
8d6c0000 // 34 lw   $12, 0($11)
01816821 // 38 addu $13, $12, $1
ad4d0008 // 3c sw   $13, 8($10)
8d6e0004 // 40 lw   $14, 4($11)
ad4e000c // 44 sw   $14, 12($10)
340f0007 // 48 ori  $15, $0, 7
11e70002 // 4c beq  $15, $7, 0x58
ad4f0010 // 50 sw   $15, 16($10)
ad410014 // 54 sw   $1, 20($10)
34100007 // 58 ori  $16, $0, 7
120f0002 // 5c beq  $16, $15, 0x68
ad500018 // 60 sw   $16, 24($10)
ad42001c // 64 sw   $2, 28($10)
0c000024 // 68 jal  0x90
ad5f0020 // 6c sw   $31, 32($10)
ad430024 // 70 sw   $3, 36($10)
34001234 // 74 ori  $0, $0, 0x1234
ad40002c // 78 sw   $0, 44($10)
0800001f // 7c j    0x7c
00000000 // 80 nop
@24
34110055 // 90 ori  $17, $0, 0x55
03e00008 // 94 jr   $31
ad510028 // 98 sw   $17, 40($10)
@40
00000002
00001234 // 100
00c0ffee // 104
@60
0000000b
00000200 00000070 // dependent add chain
00000204 00000004 // register file write-before-read
00000208 00001244 // load then dependent addu
0000020c 00c0ffee // load then store of the loaded value
00000210 00000007 // delay slot of untaken beq
00000214 00000010 // fall-through of untaken beq
00000218 00000007 // delay slot of taken beq
00000220 00000070 // link value in jal delay slot
00000228 00000055 // delay slot of jr
00000224 00000030 // return address reached
0000022c 00000000 // register 0 stays zero

// ==== sources.f ====
hw/mipsPkg.sv
hw/pipeReg.sv
hw/regFile.sv
hw/instrDecode.sv
hw/hazardUnit.sv
hw/pipelineCore.sv
verification/clockGen.sv
verification/core_asserts.sv
verification/coreTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
if ! verilator --binary --timing --assert --timescale 1ns/10ps \
        --top-module coreTb -o coreSim -f sources.f; then
    echo "build failed"
    exit 1
fi

./obj_dir/coreSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "test failed"
    exit 1
fi

# a failed assertion stops the simulator with a nonzero status
if [ "$simStatus" -ne 0 ]; then
    echo "simulator exited with status $simStatus"
    exit 1
fi

echo "test passed"
exit 0
